// File: logic/crop_macros.svh
`ifndef CROP_MACROS_SVH
`define CROP_MACROS_SVH

// width of pixel and line counters and of every border offset
`define COUNT_W 12

// offset change per arrow key
`define HSTEP 4   // pixels per left or right key
`define VSTEP 1   // lines per up or down key

// horizontal blanking
`define FORCE_MARGIN 8   // clocks kept dark at each line end
`define BLANK_LEAD 2     // border blank switches this early

// lines after vsync end before the forced vblank lifts
`define VS_TAIL 2

// pixel enable accumulator, pulse taken from its top bit
`define PIX_ACC_W 4

`endif

// File: logic/raster_pkg.sv
`default_nettype none
`include "crop_macros.svh"

package raster_pkg;

	typedef logic [`COUNT_W-1:0] count_t;

	// resolution flags from the chipset
	typedef logic [1:0] res_t;
	localparam int RES_HIRES  = 0;
	localparam int RES_SHIRES = 1;

	// screen record for the host, refreshed once per frame
	typedef struct packed {
		count_t     hbl_l;
		count_t     hbl_r;
		count_t     vbl_t;
		count_t     vbl_b;
		count_t     hsize;
		count_t     vsize;
		res_t       res;
		logic [6:0] chg_cnt;   // steps on res or size change
	} screen_info_t;

endpackage

`default_nettype wire

// File: logic/key_pkg.sv
`default_nettype none

package key_pkg;

	// host keyboard codes that move the border
	typedef enum logic [7:0] {
		KEY_BACKSPACE    = 8'h41,
		KEY_UP           = 8'h4c,
		KEY_DOWN         = 8'h4d,
		KEY_RIGHT        = 8'h4e,
		KEY_LEFT         = 8'h4f,
		KEY_LALT_PRESS   = 8'h64,
		KEY_RALT_PRESS   = 8'h65,
		KEY_LALT_RELEASE = 8'he4,
		KEY_RALT_RELEASE = 8'he5
	} key_code_e;

	// what kbd_data carries on the host channel
	typedef enum logic [1:0] {
		KBD_NONE    = 2'd0,
		KBD_MOUSE   = 2'd1,
		KBD_KEYCODE = 2'd3
	} kbd_type_e;

endpackage

`default_nettype wire

// File: logic/line_timer.sv
`timescale 1ns/1ps
`default_nettype none
`include "crop_macros.svh"

module line_timer import raster_pkg::*; (
	input  logic   clk_sys,
	input  logic   reset,
	input  logic   hs,        // active low
	input  logic   hblank,
	input  logic   field1,
	input  count_t vcnt,
	input  count_t hbl_l,
	input  count_t hbl_r,
	output logic   hbl_out,
	output count_t hsize
);

	count_t hcnt;
	count_t hend;   // count at end of hblank
	count_t hsta;   // count at start of hblank
	count_t hmax;   // line length
	logic   old_hs;
	logic   old_hblank;
	logic   shbl;   // movable border blank
	logic   fhbl;   // forced blank near sync
	logic   hblank_fall;
	logic   hblank_rise;
	logic   hs_fall;
	count_t shbl_off_at;
	count_t shbl_on_at;
	count_t fhbl_on_at;

	assign hblank_fall = old_hblank & ~hblank;
	assign hblank_rise = ~old_hblank & hblank;
	assign hs_fall     = old_hs & ~hs;

	// targets wrap at counter width
	assign shbl_off_at = hend + hbl_l - count_t'(`BLANK_LEAD);
	assign shbl_on_at  = hsta + hbl_r - count_t'(`BLANK_LEAD);
	assign fhbl_on_at  = hmax - count_t'(`FORCE_MARGIN);

	assign hbl_out = fhbl | shbl | ~hs;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hcnt       <= '0;
			hend       <= '0;
			hsta       <= '0;
			hmax       <= '0;
			hsize      <= '0;
			old_hs     <= 1'b1;
			old_hblank <= 1'b0;
			shbl       <= 1'b1;
			fhbl       <= 1'b1;
		end else begin
			old_hs     <= hs;
			old_hblank <= hblank;

			if (~hs)
				hcnt <= '0;   // restart while in sync
			else
				hcnt <= hcnt + count_t'(1);

			if (hblank_fall) hend <= hcnt;
			if (hblank_rise) hsta <= hcnt;
			if (hs_fall)     hmax <= hcnt;

			if (hcnt == shbl_off_at) shbl <= 1'b0;
			if (hcnt == shbl_on_at)  shbl <= 1'b1;

			if (hcnt == count_t'(`FORCE_MARGIN)) fhbl <= 1'b0;
			if (hcnt == fhbl_on_at)              fhbl <= 1'b1;

			// width taken on line 1 of even fields only
			if (hblank_rise & ~field1 & (vcnt == count_t'(1)))
				hsize <= hcnt - hend;
		end
	end

endmodule

`default_nettype wire

// File: logic/frame_timer.sv
`timescale 1ns/1ps
`default_nettype none
`include "crop_macros.svh"

module frame_timer import raster_pkg::*; (
	input  logic   clk_sys,
	input  logic   reset,
	input  logic   hs,        // active low
	input  logic   vs,        // active low
	input  logic   vblank,
	input  logic   lace,
	input  logic   field1,
	input  logic   hbl_out,
	input  count_t vbl_t,
	input  count_t vbl_b,
	output count_t vcnt,
	output count_t vsize,
	output logic   hde,
	output logic   vde
);

	count_t vend;       // line at end of vblank
	count_t vmax;       // lines per field
	count_t vs_end;     // line at end of vsync
	count_t f1_vend;
	count_t f1_vsize;   // active height of odd field
	logic   old_hs;
	logic   old_vs;
	logic   old_vblank;
	logic   old_hbl;
	logic   svbl;       // movable border blank
	logic   fvbl;       // forced blank around vsync
	logic   measured;   // one full field seen
	logic   vblank_rise;
	logic   vblank_fall;
	logic   line_eval;
	count_t svbl_off_at;
	count_t svbl_on_at;
	count_t fvbl_on_at;
	count_t fvbl_off_at;

	assign vblank_rise = ~old_vblank & vblank;
	assign vblank_fall = old_vblank & ~vblank;
	assign line_eval   = (old_hbl & ~hbl_out) | (vcnt == '0);

	assign svbl_off_at = vend + vbl_t;
	// negative bottom offset counts back from the field end
	assign svbl_on_at  = vbl_b[`COUNT_W-1] ? vmax + vbl_b : vbl_b;
	assign fvbl_on_at  = vmax - count_t'(1);
	assign fvbl_off_at = vs_end + count_t'(`VS_TAIL);

	assign vde = ~(fvbl | svbl);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			vcnt <= '0;
			vsize <= '0;
			vend <= '0;
			vmax <= '0;
			vs_end <= '0;
			f1_vend <= '0;
			f1_vsize <= '0;
			old_hs <= 1'b1;
			old_vs <= 1'b1;
			old_vblank <= 1'b1;
			old_hbl <= 1'b1;
			svbl <= 1'b1;
			fvbl <= 1'b1;
			measured <= 1'b0;
			hde <= 1'b0;
		end else begin
			old_hs <= hs;
			old_vs <= vs;
			old_vblank <= vblank;
			old_hbl <= hbl_out;

			if (vblank_rise)
				vcnt <= '0;
			else if (old_hs & ~hs)
				vcnt <= vcnt + count_t'(1);

			if (~lace | ~field1) begin
				if (vblank_fall)   vend <= vcnt;
				if (~old_vs & vs)  vs_end <= vcnt;
				if (vblank_rise) begin
					vmax     <= vcnt;
					vsize    <= vcnt - vend + f1_vsize;   // odd field height folded in
					f1_vsize <= '0;
					measured <= 1'b1;
				end
			end else begin
				if (vblank_fall) f1_vend <= vcnt;
				if (vblank_rise) f1_vsize <= vcnt - f1_vend;
			end

			if (line_eval) begin
				if (vcnt == svbl_off_at) svbl <= 1'b0;
				if (vcnt == svbl_on_at)  svbl <= 1'b1;
				if (vcnt == fvbl_on_at)  fvbl <= 1'b1;
				if (measured && vcnt == fvbl_off_at) fvbl <= 1'b0;
			end

			hde <= ~hbl_out & measured;
		end
	end

endmodule

`default_nettype wire

// File: logic/border_adjust.sv
`timescale 1ns/1ps
`default_nettype none
`include "crop_macros.svh"

module border_adjust import raster_pkg::*, key_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [7:0] kbd_data,
	input  kbd_type_e  kbd_type,
	input  logic       kbd_level,   // toggles per event
	input  logic       preset_load,
	input  count_t     preset_hbl_l,
	input  count_t     preset_hbl_r,
	input  count_t     preset_vbl_t,
	input  count_t     preset_vbl_b,
	output count_t     hbl_l,
	output count_t     hbl_r,
	output count_t     vbl_t,
	output count_t     vbl_b
);

	logic old_level;
	logic alt;   // arrows move right and bottom edges
	logic key_event;

	assign key_event = (old_level ^ kbd_level) && (kbd_type == KBD_KEYCODE);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_level <= 1'b0;
			alt   <= 1'b0;
			hbl_l <= '0;
			hbl_r <= '0;
			vbl_t <= '0;
			vbl_b <= '0;
		end else begin
			old_level <= kbd_level;

			if (key_event) begin
				case (kbd_data)
					KEY_BACKSPACE: begin
						hbl_l <= '0;
						hbl_r <= '0;
						vbl_t <= '0;
						vbl_b <= '0;
					end
					KEY_UP:
						if (alt)
							vbl_b <= vbl_b + count_t'(`VSTEP);
						else
							vbl_t <= vbl_t + count_t'(`VSTEP);
					KEY_DOWN:
						if (alt)
							vbl_b <= vbl_b - count_t'(`VSTEP);
						else
							vbl_t <= vbl_t - count_t'(`VSTEP);
					KEY_LEFT:
						if (alt)
							hbl_r <= hbl_r + count_t'(`HSTEP);
						else
							hbl_l <= hbl_l + count_t'(`HSTEP);
					KEY_RIGHT:
						if (alt)
							hbl_r <= hbl_r - count_t'(`HSTEP);
						else
							hbl_l <= hbl_l - count_t'(`HSTEP);
					KEY_LALT_PRESS, KEY_RALT_PRESS:     alt <= 1'b1;
					KEY_LALT_RELEASE, KEY_RALT_RELEASE: alt <= 1'b0;
					default: ;
				endcase
			end

			// preset wins over a key in the same clock
			if (preset_load) begin
				hbl_l <= preset_hbl_l;
				hbl_r <= preset_hbl_r;
				vbl_t <= preset_vbl_t;
				vbl_b <= preset_vbl_b;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/screen_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module screen_monitor import raster_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         vblank,
	input  res_t         res,
	input  count_t       hbl_l,
	input  count_t       hbl_r,
	input  count_t       vbl_t,
	input  count_t       vbl_b,
	input  count_t       hsize,
	input  count_t       vsize,
	output screen_info_t info
);

	logic old_vblank;
	logic changed;   // against last latched record

	assign changed = (info.res != res) || (info.hsize != hsize) || (info.vsize != vsize);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vblank <= 1'b0;
			info <= '0;
		end else begin
			old_vblank <= vblank;

			// latch once per frame at start of display
			if (old_vblank & ~vblank) begin
				info.hbl_l <= hbl_l;
				info.hbl_r <= hbl_r;
				info.vbl_t <= vbl_t;
				info.vbl_b <= vbl_b;
				info.hsize <= hsize;
				info.vsize <= vsize;
				info.res   <= res;
				if (changed)
					info.chg_cnt <= info.chg_cnt + 7'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/pixel_rate.sv
`timescale 1ns/1ps
`default_nettype none
`include "crop_macros.svh"

module pixel_rate import raster_pkg::*; (
	input  logic clk_sys,
	input  logic reset,
	input  logic vs,         // active low
	input  logic hblank,
	input  logic vblank,
	input  logic fast_pix,
	input  res_t res,
	output logic ce_pix
);

	logic [`PIX_ACC_W-1:0] acc;
	logic [`PIX_ACC_W-1:0] acc_sum;
	logic [`PIX_ACC_W-1:0] step;   // 1, 2 or 4
	res_t fs_res;                  // res seen this frame
	logic old_vs;

	assign acc_sum = acc + step;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			acc <= '0;
			step <= `PIX_ACC_W'(1);
			fs_res <= '0;
			old_vs <= 1'b1;
			ce_pix <= 1'b0;
		end else begin
			old_vs <= vs;
			ce_pix <= acc_sum[`PIX_ACC_W-1];   // reached 8
			acc <= {1'b0, acc_sum[`PIX_ACC_W-2:0]};

			if (~hblank & ~vblank) fs_res <= fs_res | res;

			// rate for the next frame
			if (old_vs & ~vs) begin
				fs_res <= '0;
				acc <= '0;
				step <= `PIX_ACC_W'(1);
				if (fs_res[RES_HIRES]) step <= `PIX_ACC_W'(2);
				if (fs_res[RES_SHIRES] | fast_pix) step <= `PIX_ACC_W'(4);
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/video_crop.sv
`timescale 1ns/1ps
`default_nettype none

module video_crop import raster_pkg::*, key_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         hs,          // active low
	input  logic         vs,          // active low
	input  logic         hblank,
	input  logic         vblank_in,
	input  logic         field1,
	input  logic         lace,
	input  res_t         res,
	input  logic [7:0]   kbd_data,
	input  kbd_type_e    kbd_type,
	input  logic         kbd_level,
	input  logic         preset_load,
	input  count_t       preset_hbl_l,
	input  count_t       preset_hbl_r,
	input  count_t       preset_vbl_t,
	input  count_t       preset_vbl_b,
	input  logic         fast_pix,
	output logic         hde,
	output logic         vde,
	output logic         ce_pix,
	output screen_info_t info
);

	logic   vblank;
	logic   hbl_out;
	count_t vcnt;
	count_t hsize;
	count_t vsize;
	count_t hbl_l;
	count_t hbl_r;
	count_t vbl_t;
	count_t vbl_b;

	assign vblank = vblank_in | ~vs;   // vsync counts as blank

	line_timer i_line_timer (
		.clk_sys (clk_sys), .reset (reset),
		.hs      (hs),      .hblank (hblank), .field1 (field1),
		.vcnt    (vcnt),    .hbl_l  (hbl_l),  .hbl_r  (hbl_r),
		.hbl_out (hbl_out), .hsize  (hsize)
	);

	frame_timer i_frame_timer (
		.clk_sys (clk_sys), .reset (reset),
		.hs      (hs),      .vs    (vs),    .vblank (vblank),
		.lace    (lace),    .field1 (field1), .hbl_out (hbl_out),
		.vbl_t   (vbl_t),   .vbl_b (vbl_b),
		.vcnt    (vcnt),    .vsize (vsize), .hde (hde), .vde (vde)
	);

	border_adjust i_border_adjust (
		.clk_sys (clk_sys), .reset (reset),
		.kbd_data (kbd_data), .kbd_type (kbd_type), .kbd_level (kbd_level),
		.preset_load (preset_load),
		.preset_hbl_l (preset_hbl_l), .preset_hbl_r (preset_hbl_r),
		.preset_vbl_t (preset_vbl_t), .preset_vbl_b (preset_vbl_b),
		.hbl_l (hbl_l), .hbl_r (hbl_r), .vbl_t (vbl_t), .vbl_b (vbl_b)
	);

	screen_monitor i_screen_monitor (
		.clk_sys (clk_sys), .reset (reset), .vblank (vblank), .res (res),
		.hbl_l (hbl_l), .hbl_r (hbl_r), .vbl_t (vbl_t), .vbl_b (vbl_b),
		.hsize (hsize), .vsize (vsize), .info (info)
	);

	pixel_rate i_pixel_rate (
		.clk_sys (clk_sys), .reset (reset),
		.vs (vs), .hblank (hblank), .vblank (vblank),
		.fast_pix (fast_pix), .res (res), .ce_pix (ce_pix)
	);

endmodule

`default_nettype wire

// File: test/video_crop_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module video_crop_assertions import raster_pkg::*; (
	input logic         clk_sys,
	input logic         reset,
	input logic         hs,
	input logic         vblank,
	input logic         hde,
	input logic         ce_pix,
	input screen_info_t info
);

	// pixel enable is a single clock pulse
	ce_single: assert property (@(posedge clk_sys) disable iff (reset)
		ce_pix |=> !ce_pix)
		else $error("ce_pix high on two consecutive clocks");

	hde_sync: assert property (@(posedge clk_sys) disable iff (reset)
		!hs |-> !hde)
		else $error("hde high during hsync");

	// record written only on the clock after vblank falls
	info_latch: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(info) |-> ($past(vblank, 2) && !$past(vblank)))
		else $error("info changed outside the vblank fall");

endmodule

bind video_crop video_crop_assertions i_assertions (
	.clk_sys (clk_sys), .reset (reset), .hs (hs), .vblank (vblank),
	.hde (hde), .ce_pix (ce_pix), .info (info)
);

`default_nettype wire

// File: test/tb_video_crop.sv
`timescale 1ns/1ps
`default_nettype none
`include "crop_macros.svh"

module tb_video_crop import raster_pkg::*, key_pkg::*; ();

	// raster geometry, line 0 starts with hsync and vsync
	localparam int H_TOTAL = 100;
	localparam int HS_LEN = 8;
	localparam int HB_END = 24;
	localparam int HB_START = 88;
	localparam int V_TOTAL = 20;
	localparam int VS_LEN = 2;
	localparam int VB_END = 5;
	localparam int VB_START = 17;
	localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;
	localparam int N_ROWS = 14;

	typedef struct {
		int nrand;           // random arrow keys, else the fixed list
		logic [31:0] keys;   // byte 0 sent first
		int nkeys;
		bit preset;
		count_t p_l, p_r, p_t, p_b;
		res_t res;
		bit lace, field1, fast;
		count_t e_hsize, e_vsize;
		int e_chg;
	} row_t;

	logic clk_sys, reset, hs, vs, hblank, vblank_in, field1, lace;
	res_t res;
	logic [7:0] kbd_data;
	kbd_type_e kbd_type;
	logic kbd_level, preset_load, fast_pix;
	count_t preset_hbl_l, preset_hbl_r, preset_vbl_t, preset_vbl_b;
	logic hde, vde, ce_pix;
	screen_info_t info;

	row_t rows [N_ROWS];
	logic [7:0] key_q [$];
	logic [31:0] lfsr = 32'h3fc3276b;
	int errors = 0;
	int checks = 0;
	int row_errs;
	count_t m_l, m_r, m_t, m_b;   // offset model
	logic m_alt;
	res_t prev_res;
	int hde_cnt, gap_min, gap_max;
	int early_de;   // enables seen before the first field ends

	video_crop i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (N_ROWS * FRAME_CLKS * 2 + 10) @(posedge clk_sys);
		$display("watchdog expired before all rows finished");
		$display("Simulation failed");
		$finish;
	end

	function automatic logic rand_bit();
		logic b;
		b = lfsr[0];
		lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);
		return b;
	endfunction

	task automatic check_value(input string name, input logic [95:0] got, input logic [95:0] exp);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got %0h expected %0h", $time, name, got, exp);
			errors++;
			row_errs++;
		end
	endtask

	// border rules for one key, values wrap at counter width
	task automatic model_key(input logic [7:0] code);
		case (code)
			8'h41: {m_l, m_r, m_t, m_b} = '0;
			8'h4c: if (m_alt) m_b = m_b + 1; else m_t = m_t + 1;
			8'h4d: if (m_alt) m_b = m_b - 1; else m_t = m_t - 1;
			8'h4f: if (m_alt) m_r = m_r + 4; else m_l = m_l + 4;
			8'h4e: if (m_alt) m_r = m_r - 4; else m_l = m_l - 4;
			8'h64, 8'h65: m_alt = 1'b1;
			8'he4, 8'he5: m_alt = 1'b0;
			default: ;
		endcase
	endtask

	task automatic run_frame(input row_t rw);
		int idx, last;
		last = -1;
		hde_cnt = 0;
		early_de = 0;
		gap_min = 1 << 20;
		gap_max = 0;
		for (int ln = 0; ln < V_TOTAL; ln++) begin
			for (int x = 0; x < H_TOTAL; x++) begin
				@(posedge clk_sys);
				idx = ln * H_TOTAL + x;
				hs <= (x >= HS_LEN);
				vs <= (ln >= VS_LEN);
				hblank <= (x < HB_END) || (x >= HB_START);
				vblank_in <= (ln < VB_END) || (ln >= VB_START);
				if (idx == 0) begin
					res <= rw.res;
					lace <= rw.lace;
					field1 <= rw.field1;
					fast_pix <= rw.fast;
					preset_load <= rw.preset;
					{preset_hbl_l, preset_hbl_r} <= {rw.p_l, rw.p_r};
					{preset_vbl_t, preset_vbl_b} <= {rw.p_t, rw.p_b};
				end
				if (idx == 1) preset_load <= 1'b0;
				if (ln < VB_END && idx > 0 && idx % 4 == 0 && key_q.size() > 0) begin
					kbd_data <= key_q.pop_front();
					kbd_level <= ~kbd_level;
				end
				@(negedge clk_sys);
				if (ce_pix) begin
					if (last >= 8) begin   // skip pulses left from the old rate
						if (idx - last < gap_min) gap_min = idx - last;
						if (idx - last > gap_max) gap_max = idx - last;
					end
					last = idx;
				end
				if (ln >= VB_END && hde) hde_cnt++;
				if (ln < VB_START && (hde || vde)) early_de++;
			end
		end
	endtask

	initial begin
		int per_line, period, de_lines;
		logic [2:0] pick;
		logic [7:0] rnd_codes [8];
		rnd_codes = '{8'h4c, 8'h4d, 8'h4e, 8'h4f, 8'h64, 8'h65, 8'he4, 8'he5};
		// nrand keys nkeys preset l r t b res lace f1 fast hsize vsize chg
		rows[0] = '{0, 32'h0, 0, 0, 0, 0, 0, 0, 2'd0, 0, 0, 0, 64, 0, 1};
		rows[1] = '{0, 32'h0, 0, 0, 0, 0, 0, 0, 2'd0, 0, 0, 0, 64, 12, 2};
		rows[2] = '{0, 32'h4d644c4f, 4, 0, 0, 0, 0, 0, 2'd0, 0, 0, 0, 64, 12, 2};
		rows[3] = '{0, 32'h004ee54f, 3, 0, 0, 0, 0, 0, 2'd1, 0, 0, 0, 64, 12, 3};
		rows[4] = '{0, 32'h41, 1, 0, 0, 0, 0, 0, 2'd1, 0, 0, 0, 64, 12, 3};
		rows[5] = '{8, 32'h0, 0, 0, 0, 0, 0, 0, 2'd1, 0, 0, 0, 64, 12, 3};
		rows[6] = '{0, 32'h4f4c, 2, 1, 10, 20, 3, 2, 2'd2, 0, 0, 0, 64, 12, 4};
		rows[7] = '{0, 32'h41, 1, 0, 0, 0, 0, 0, 2'd0, 0, 0, 1, 64, 12, 5};
		rows[8] = '{0, 32'h0, 0, 0, 0, 0, 0, 0, 2'd0, 1, 1, 1, 64, 12, 5};
		rows[9] = '{0, 32'h0, 0, 0, 0, 0, 0, 0, 2'd0, 1, 0, 0, 64, 12, 5};
		rows[10] = '{0, 32'h0, 0, 0, 0, 0, 0, 0, 2'd0, 1, 1, 0, 64, 24, 6};
		rows[11] = '{0, 32'h0, 0, 0, 0, 0, 0, 0, 2'd0, 0, 0, 0, 64, 24, 6};
		rows[12] = '{12, 32'h0, 0, 0, 0, 0, 0, 0, 2'd0, 0, 0, 0, 64, 24, 6};
		rows[13] = '{0, 32'h41, 1, 0, 0, 0, 0, 0, 2'd0, 0, 0, 0, 64, 12, 7};

		// inputs start as line 0, pixel 0
		reset = 1'b1;
		{hs, vs, hblank, vblank_in, field1, lace, res} = {4'b0011, 2'b00, 2'd0};
		{kbd_data, kbd_level, preset_load, fast_pix} = '0;
		kbd_type = KBD_KEYCODE;
		{preset_hbl_l, preset_hbl_r, preset_vbl_t, preset_vbl_b} = '0;
		{m_l, m_r, m_t, m_b, m_alt} = '0;
		prev_res = '0;
		row_errs = 0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("info", info, '0);
		check_value("hde", hde, 0);
		check_value("vde", vde, 0);
		@(posedge clk_sys);
		reset <= 1'b0;

		// enable window per line, border blank against forced margins
		per_line = ((HB_START - `BLANK_LEAD < H_TOTAL - `FORCE_MARGIN) ?
			HB_START - `BLANK_LEAD : H_TOTAL - `FORCE_MARGIN) -
			((HB_END - 1 > HS_LEN + `FORCE_MARGIN + 1) ?
			HB_END - 1 : HS_LEN + `FORCE_MARGIN + 1) + 1;

		for (int r = 0; r < N_ROWS; r++) begin
			row_errs = 0;
			key_q.delete();
			if (rows[r].preset) begin
				{m_l, m_r} = {rows[r].p_l, rows[r].p_r};
				{m_t, m_b} = {rows[r].p_t, rows[r].p_b};
			end
			for (int k = 0; k < rows[r].nkeys; k++)
				key_q.push_back(rows[r].keys[8*k +: 8]);
			for (int k = 0; k < rows[r].nrand; k++) begin
				for (int b = 0; b < 3; b++)
					pick[b] = rand_bit();
				key_q.push_back(rnd_codes[pick]);
			end
			foreach (key_q[k])
				model_key(key_q[k]);
			period = (prev_res[1] || rows[r].fast) ? 2 : (prev_res[0] ? 4 : 8);

			run_frame(rows[r]);

			check_value("info.hbl_l", info.hbl_l, m_l);
			check_value("info.hbl_r", info.hbl_r, m_r);
			check_value("info.vbl_t", info.vbl_t, m_t);
			check_value("info.vbl_b", info.vbl_b, m_b);
			check_value("info.hsize", info.hsize, rows[r].e_hsize);
			check_value("info.vsize", info.vsize, rows[r].e_vsize);
			check_value("info.res", info.res, rows[r].res);
			check_value("info.chg_cnt", info.chg_cnt, rows[r].e_chg);
			check_value("ce_pix gap min", gap_min, period);
			check_value("ce_pix gap max", gap_max, period);
			// first frame opens the enables only once its field has ended
			de_lines = (r == 0) ? V_TOTAL - VB_START : V_TOTAL - VB_END;
			if (m_l == '0 && m_r == '0)
				check_value("hde count", hde_cnt, per_line * de_lines);
			if (r == 0)
				check_value("hde or vde before first field", early_de, 0);
			prev_res = rows[r].res;
			$display("row %0d: %s", r, (row_errs == 0) ? "ok" : "errors");
		end

		$display("rows %0d, checks %0d, errors %0d", N_ROWS, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/raster_pkg.sv
logic/key_pkg.sv
logic/line_timer.sv
logic/frame_timer.sv
logic/border_adjust.sv
logic/screen_monitor.sv
logic/pixel_rate.sv
logic/video_crop.sv
test/video_crop_assertions.sv
test/tb_video_crop.sv

// File: run_sim.sh
#!/bin/sh
# build and run the video_crop testbench with Verilator
set -u

LOG=sim.log

verilator --binary --assert -j 0 -f sim.f --top-module tb_video_crop -o tb_video_crop
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_video_crop > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
	echo "no result line in $LOG"
	exit 1
fi
exit 0
